// ==== design/secv_pkg.sv ====
// Shared sizes and types for the memory unit; bus address is a word index, no byte offsets
package secv_pkg;

    // Data path and bus sizes
    localparam int XLEN      = 64;
    localparam int ADR_WIDTH = 8;
    localparam int SEL_WIDTH = XLEN / 8;

    // Any address with all of these bits set is refused
    localparam logic [ADR_WIDTH-1:0] ADR_FAULT_MASK = 8'h80;

    // Data memory geometry
    localparam int DMEM_DEPTH     = 128;
    localparam int DMEM_IDX_WIDTH = $clog2(DMEM_DEPTH);

    // Byte-lane selects per access width, always the low lanes
    localparam logic [SEL_WIDTH-1:0] SEL_BYTE   = 8'h01;
    localparam logic [SEL_WIDTH-1:0] SEL_HALF   = 8'h03;
    localparam logic [SEL_WIDTH-1:0] SEL_WORD   = 8'h0f;
    localparam logic [SEL_WIDTH-1:0] SEL_DOUBLE = 8'hff;

    // Memory ops; codes 11 to 15 are left unnamed and decode as invalid
    typedef enum logic [3:0] {
        MEM_OP_LB  = 4'd0,
        MEM_OP_LH  = 4'd1,
        MEM_OP_LW  = 4'd2,
        MEM_OP_LD  = 4'd3,
        MEM_OP_LBU = 4'd4,
        MEM_OP_LHU = 4'd5,
        MEM_OP_LWU = 4'd6,
        MEM_OP_SB  = 4'd7,
        MEM_OP_SH  = 4'd8,
        MEM_OP_SW  = 4'd9,
        MEM_OP_SD  = 4'd10
    } mem_op_t;

    // Error codes returned with rdy
    typedef enum logic [1:0] {
        ERROR_NONE               = 2'd0,
        ERROR_OP_INVALID         = 2'd1,
        ERROR_LOAD_ACCESS_FAULT  = 2'd2,
        ERROR_STORE_ACCESS_FAULT = 2'd3
    } error_t;

    // Request into a function unit
    typedef struct packed {
        logic            ena;
        mem_op_t         op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } funit_in_t;

    // Response from a function unit
    typedef struct packed {
        logic            rdy;
        error_t          err;
        logic [XLEN-1:0] res;
        logic            res_wb;
    } funit_out_t;

    // Wishbone-style data bus request
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic [SEL_WIDTH-1:0] sel;
        logic [ADR_WIDTH-1:0] adr;
        logic                 we;
        logic [XLEN-1:0]      dat;
    } dmem_req_t;

    // Idle response
    function automatic funit_out_t funit_out_default();
        funit_out_t out;
        out.rdy    = 1'b0;
        out.err    = ERROR_NONE;
        out.res    = '0;
        out.res_wb = 1'b0;
        return out;
    endfunction

    function automatic logic [XLEN-1:0] sext8(input logic [7:0] val);
        return {{(XLEN-8){val[7]}}, val};
    endfunction

    function automatic logic [XLEN-1:0] sext16(input logic [15:0] val);
        return {{(XLEN-16){val[15]}}, val};
    endfunction

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] val);
        return {{(XLEN-32){val[31]}}, val};
    endfunction

endpackage

// ==== design/secv_mem.sv ====
// Combinational memory unit; holds no state, so the requester keeps ena and operands until rdy
`timescale 1ns/1ps

module secv_mem (
    // Function unit side
    input  secv_pkg::funit_in_t           fu_i,
    output secv_pkg::funit_out_t          fu_o,

    // Data bus side
    output secv_pkg::dmem_req_t           dmem_req_o,
    input  logic [secv_pkg::XLEN-1:0]     dmem_dat_i,
    input  logic                          dmem_ack_i
);

    import secv_pkg::*;

    logic [ADR_WIDTH-1:0] adr;
    logic [SEL_WIDTH-1:0] sel;
    logic [XLEN-1:0]      wdat;
    logic [XLEN-1:0]      ldat;
    logic                 load;
    logic                 we;
    logic                 op_ok;
    logic                 fault;
    error_t               err;

    // Word index taken from the low bits of the address operand
    assign adr   = fu_i.src1[ADR_WIDTH-1:0];
    assign fault = (adr & ADR_FAULT_MASK) == ADR_FAULT_MASK;

    // Op decode into lanes, direction and store data
    always_comb begin : op_decode
        load  = 1'b0;
        we    = 1'b0;
        sel   = '0;
        wdat  = '0;
        op_ok = 1'b1;

        case (fu_i.op)
            MEM_OP_LB, MEM_OP_LBU: begin
                sel  = SEL_BYTE;
                load = 1'b1;
            end
            MEM_OP_LH, MEM_OP_LHU: begin
                sel  = SEL_HALF;
                load = 1'b1;
            end
            MEM_OP_LW, MEM_OP_LWU: begin
                sel  = SEL_WORD;
                load = 1'b1;
            end
            MEM_OP_LD: begin
                sel  = SEL_DOUBLE;
                load = 1'b1;
            end
            MEM_OP_SB: begin
                sel        = SEL_BYTE;
                we         = 1'b1;
                wdat[7:0]  = fu_i.src2[7:0];
            end
            MEM_OP_SH: begin
                sel        = SEL_HALF;
                we         = 1'b1;
                wdat[15:0] = fu_i.src2[15:0];
            end
            MEM_OP_SW: begin
                sel        = SEL_WORD;
                we         = 1'b1;
                wdat[31:0] = fu_i.src2[31:0];
            end
            MEM_OP_SD: begin
                sel  = SEL_DOUBLE;
                we   = 1'b1;
                wdat = fu_i.src2;
            end
            default: op_ok = 1'b0;
        endcase
    end

    // Sign or zero extension of the returned word
    always_comb begin : load_shape
        case (fu_i.op)
            MEM_OP_LB:  ldat = sext8(dmem_dat_i[7:0]);
            MEM_OP_LH:  ldat = sext16(dmem_dat_i[15:0]);
            MEM_OP_LW:  ldat = sext32(dmem_dat_i[31:0]);
            MEM_OP_LD:  ldat = dmem_dat_i;
            MEM_OP_LBU: ldat = {{(XLEN-8){1'b0}}, dmem_dat_i[7:0]};
            MEM_OP_LHU: ldat = {{(XLEN-16){1'b0}}, dmem_dat_i[15:0]};
            MEM_OP_LWU: ldat = {{(XLEN-32){1'b0}}, dmem_dat_i[31:0]};
            default:    ldat = '0;
        endcase
    end

    // Fault wins over an invalid op, which then counts as a store
    always_comb begin : err_select
        if (fault) begin
            err = load ? ERROR_LOAD_ACCESS_FAULT : ERROR_STORE_ACCESS_FAULT;
        end else if (!op_ok) begin
            err = ERROR_OP_INVALID;
        end else begin
            err = ERROR_NONE;
        end
    end

    // Bus cycle only for a legal op at a legal address
    always_comb begin : bus_request
        dmem_req_o = '0;
        if (fu_i.ena && err == ERROR_NONE) begin
            dmem_req_o.cyc = 1'b1;
            dmem_req_o.stb = 1'b1;
            dmem_req_o.sel = sel;
            dmem_req_o.adr = adr;
            dmem_req_o.we  = we;
            dmem_req_o.dat = wdat;
        end
    end

    // Response, idle while ena is low
    always_comb begin : fu_response
        fu_o = funit_out_default();
        if (fu_i.ena) begin
            fu_o.rdy    = (err != ERROR_NONE) || dmem_ack_i;
            fu_o.err    = err;
            fu_o.res    = ldat;
            fu_o.res_wb = load && (err == ERROR_NONE);
        end
    end

endmodule

// ==== design/secv_dmem.sv ====
// Synchronous data memory; words indexed by the low seven address bits, contents not reset
`timescale 1ns/1ps

module secv_dmem (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Bus slave port
    input  secv_pkg::dmem_req_t       dmem_req_i,
    output logic [secv_pkg::XLEN-1:0] dmem_dat_o,
    output logic                      dmem_ack_o
);

    import secv_pkg::*;

    logic [XLEN-1:0]           mem_q [DMEM_DEPTH];
    logic [DMEM_IDX_WIDTH-1:0] idx;
    logic                      accept;

    assign idx = dmem_req_i.adr[DMEM_IDX_WIDTH-1:0];

    // A request is taken once; the ack cycle blocks a second accept
    assign accept = dmem_req_i.cyc && dmem_req_i.stb && !dmem_ack_o;

    // One-cycle ack pulse
    always_ff @(posedge clk_i) begin : ack_reg
        if (rst_i) begin
            dmem_ack_o <= 1'b0;
        end else begin
            dmem_ack_o <= accept;
        end
    end

    // Byte-lane write or full-word read on the accepting edge
    always_ff @(posedge clk_i) begin : mem_access
        if (accept) begin
            if (dmem_req_i.we) begin
                for (int b = 0; b < SEL_WIDTH; b++) begin
                    if (dmem_req_i.sel[b]) begin
                        mem_q[idx][8*b +: 8] <= dmem_req_i.dat[8*b +: 8];
                    end
                end
            end else begin
                // Read word held until the next accepted read
                dmem_dat_o <= mem_q[idx];
            end
        end
    end

endmodule

// ==== design/secv_mem_top.sv ====
// Memory unit with its data memory; one request in flight, loads and stores take one cycle
`timescale 1ns/1ps

module secv_mem_top (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Function unit port
    input  secv_pkg::funit_in_t  fu_i,
    output secv_pkg::funit_out_t fu_o
);

    import secv_pkg::*;

    // Data bus between unit and memory
    dmem_req_t       dmem_req;
    logic [XLEN-1:0] dmem_dat;
    logic            dmem_ack;

    secv_mem u_mem (
        .fu_i       (fu_i),
        .fu_o       (fu_o),
        .dmem_req_o (dmem_req),
        .dmem_dat_i (dmem_dat),
        .dmem_ack_i (dmem_ack)
    );

    secv_dmem u_dmem (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .dmem_req_i (dmem_req),
        .dmem_dat_o (dmem_dat),
        .dmem_ack_o (dmem_ack)
    );

endmodule

// ==== dv/secv_mem_sva.sv ====
// Protocol checks on the unit and its bus, sampled on rising clk_i; bus rules idle in reset
`timescale 1ns/1ps

module secv_mem_sva (
    input logic                 clk_i,
    input logic                 rst_i,
    input secv_pkg::funit_in_t  fu_req_i,
    input secv_pkg::funit_out_t fu_rsp_i,
    input secv_pkg::dmem_req_t  dmem_req_i,
    input logic                 dmem_ack_i
);

    import secv_pkg::*;

    logic adr_fault;

    assign adr_fault = (fu_req_i.src1[ADR_WIDTH-1:0] & ADR_FAULT_MASK) == ADR_FAULT_MASK;

    // Memory answers only a strobe from the previous edge
    ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_ack_i |-> $past(dmem_req_i.stb))
        else $error("bus ack without a strobe on the previous edge");

    rdy_needs_ena: assert property (@(posedge clk_i)
        fu_rsp_i.rdy |-> fu_req_i.ena)
        else $error("rdy high while ena is low");

    wb_without_error: assert property (@(posedge clk_i)
        fu_rsp_i.res_wb |-> fu_rsp_i.err == ERROR_NONE)
        else $error("writeback flagged together with an error code");

    // A refused address never reaches the memory
    no_cyc_on_fault: assert property (@(posedge clk_i) disable iff (rst_i)
        (fu_req_i.ena && adr_fault) |-> !dmem_req_i.cyc)
        else $error("bus cycle started for a faulting address");

endmodule

bind secv_mem_top secv_mem_sva u_sva (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fu_req_i   (fu_i),
    .fu_rsp_i   (fu_o),
    .dmem_req_i (dmem_req),
    .dmem_ack_i (dmem_ack)
);

// ==== dv/secv_mem_tb.sv ====
// Bench for secv_mem_top; 40 ns clock, inputs driven 2 ns after the rising edge, seed 43
`timescale 1ns/1ps

module secv_mem_tb;

    import secv_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int RDY_TIMEOUT  = 20;
    localparam int RAND_OPS     = 200;
    localparam int SEED         = 43;

    logic       clk_i;
    logic       rst_i;
    funit_in_t  fu_i;
    funit_out_t fu_o;

    // Reference copy of the data memory
    logic [XLEN-1:0] model [DMEM_DEPTH];

    // Handshake results waiting for comparison
    funit_out_t exp_q [$];
    funit_out_t act_q [$];
    int         lat_q [$];
    string      tag_q [$];

    int check_cnt   = 0;
    int err_cnt     = 0;
    int timeout_cnt = 0;

    secv_mem_top dut (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .fu_i  (fu_i),
        .fu_o  (fu_o)
    );

    initial clk_i = 1'b0;
    always #CLK_HALF clk_i = ~clk_i;

    // Fill word that depends on every address bit
    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return 64'h9e37_79b9_7f4a_7c15 * 64'(idx + 1);
    endfunction

    // Address operand with random upper bits around a chosen word index
    function automatic logic [XLEN-1:0] addr_with_index(input logic [ADR_WIDTH-1:0] adr);
        logic [XLEN-1:0] val;
        val = {$urandom(), $urandom()};
        val[ADR_WIDTH-1:0] = adr;
        return val;
    endfunction

    // Expected response; legal stores update the model
    function automatic funit_out_t predict(input mem_op_t op, input logic [XLEN-1:0] addr,
                                           input logic [XLEN-1:0] data);
        funit_out_t             want;
        logic [ADR_WIDTH-1:0]   adr;
        logic [XLEN-1:0]        mask;
        logic [XLEN-1:0]        word;
        logic signed [XLEN-1:0] sword;
        int                     nbytes;
        int                     sh;
        logic                   is_load;
        logic                   is_signed;

        want      = '0;
        want.rdy  = 1'b1;
        adr       = addr[ADR_WIDTH-1:0];
        is_load   = (op <= MEM_OP_LWU);
        is_signed = (op == MEM_OP_LB) || (op == MEM_OP_LH) || (op == MEM_OP_LW);
        case (op)
            MEM_OP_LB, MEM_OP_LBU, MEM_OP_SB: nbytes = 1;
            MEM_OP_LH, MEM_OP_LHU, MEM_OP_SH: nbytes = 2;
            MEM_OP_LW, MEM_OP_LWU, MEM_OP_SW: nbytes = 4;
            MEM_OP_LD, MEM_OP_SD:             nbytes = 8;
            default:                          nbytes = 0;
        endcase
        mask = (nbytes == 8) ? '1 : (64'd1 << (8 * nbytes)) - 64'd1;
        sh   = XLEN - 8 * nbytes;

        if ((adr & ADR_FAULT_MASK) == ADR_FAULT_MASK) begin
            want.err = is_load ? ERROR_LOAD_ACCESS_FAULT : ERROR_STORE_ACCESS_FAULT;
        end else if (nbytes == 0) begin
            want.err = ERROR_OP_INVALID;
        end else if (is_load) begin
            word = model[adr[DMEM_IDX_WIDTH-1:0]];
            if (is_signed) begin
                // Move the top loaded bit to bit 63, then shift back arithmetically
                sword    = word << sh;
                want.res = sword >>> sh;
            end else begin
                want.res = word & mask;
            end
            want.res_wb = 1'b1;
        end else begin
            word = model[adr[DMEM_IDX_WIDTH-1:0]];
            model[adr[DMEM_IDX_WIDTH-1:0]] = (word & ~mask) | (data & mask);
        end
        return want;
    endfunction

    task automatic expect_idle(input string phase);
        check_cnt++;
        assert (fu_o.rdy == 1'b0) else begin
            err_cnt++;
            $display("CHECK FAILED at %0t: rdy high with ena low %s", $time, phase);
        end
    endtask

    // One request; entered and left 2 ns after a rising edge
    task automatic issue(input mem_op_t op, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] data);
        funit_out_t want;
        int         waited;
        bit         got;

        want      = predict(op, addr, data);
        fu_i.ena  = 1'b1;
        fu_i.op   = op;
        fu_i.src1 = addr;
        fu_i.src2 = data;
        waited    = 0;
        got       = 1'b0;
        // rdy seen at the falling edge holds through the next rising edge
        while (!got && waited < RDY_TIMEOUT) begin
            @(negedge clk_i);
            if (fu_o.rdy) begin
                got = 1'b1;
            end else begin
                waited++;
            end
        end
        if (got) begin
            exp_q.push_back(want);
            act_q.push_back(fu_o);
            lat_q.push_back(waited);
            tag_q.push_back($sformatf("op %0d adr %02h", op, addr[ADR_WIDTH-1:0]));
        end else begin
            timeout_cnt++;
            $display("ERROR at %0t: no ready came from the DUT within %0d cycles for op %0d",
                     $time, RDY_TIMEOUT, op);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        fu_i.ena = 1'b0;
    endtask

    // Compare every completed handshake against its prediction
    always @(posedge clk_i) begin : compare
        funit_out_t want;
        funit_out_t got;
        int         lat;
        string      tag;

        while (act_q.size() > 0) begin
            want = exp_q.pop_front();
            got  = act_q.pop_front();
            lat  = lat_q.pop_front();
            tag  = tag_q.pop_front();
            check_cnt++;
            assert (got.err == want.err) else begin
                err_cnt++;
                $display("CHECK FAILED at %0t: %s err %0d, expected %0d",
                         $time, tag, got.err, want.err);
            end
            assert (got.res_wb == want.res_wb) else begin
                err_cnt++;
                $display("CHECK FAILED at %0t: %s res_wb %0b, expected %0b",
                         $time, tag, got.res_wb, want.res_wb);
            end
            if (want.res_wb) begin
                assert (got.res == want.res) else begin
                    err_cnt++;
                    $display("CHECK FAILED at %0t: %s res %016h, expected %016h",
                             $time, tag, got.res, want.res);
                end
            end
            // Errors answer at once, bus accesses after one cycle
            assert (lat == ((want.err == ERROR_NONE) ? 1 : 0)) else begin
                err_cnt++;
                $display("CHECK FAILED at %0t: %s rdy after %0d cycles", $time, tag, lat);
            end
        end
    end

    initial begin : stimulus
        int              i;
        int              k;
        logic [XLEN-1:0] pattern;

        void'($urandom(SEED));
        rst_i = 1'b1;
        fu_i  = '0;
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            expect_idle("during reset");
        end
        rst_i = 1'b0;
        for (i = 0; i < 3; i++) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            expect_idle("after reset");
        end

        // Known contents everywhere before any load
        for (i = 0; i < DMEM_DEPTH; i++) begin
            issue(MEM_OP_SD, addr_with_index(8'(i)), fill_word(i));
        end

        // Each load width over a negative and a positive pattern
        for (i = 0; i < 2; i++) begin
            pattern = (i == 0) ? 64'hf0e1_d2c3_84a5_9687 : 64'h0123_4567_7f6e_5d4c;
            issue(MEM_OP_SD, addr_with_index(8'd5), pattern);
            for (k = 0; k <= 6; k++) begin
                issue(mem_op_t'(4'(k)), addr_with_index(8'd5), {$urandom(), $urandom()});
            end
        end

        // Narrow stores leave the upper lanes alone
        for (k = 7; k <= 9; k++) begin
            issue(MEM_OP_SD, addr_with_index(8'd9), '1);
            issue(mem_op_t'(4'(k)), addr_with_index(8'd9), 64'h0bad_cafe_1234_5678);
            issue(MEM_OP_LD, addr_with_index(8'd9), '0);
        end

        // Faulting addresses, then the aliased word
        issue(MEM_OP_SD, addr_with_index(8'h94), 64'h1111_2222_3333_4444);
        issue(MEM_OP_SB, addr_with_index(8'h94), 64'h5555_6666_7777_8888);
        issue(MEM_OP_LD, addr_with_index(8'h94), '0);
        issue(MEM_OP_LWU, addr_with_index(8'hff), '0);
        issue(MEM_OP_SW, addr_with_index(8'hff), 64'h9999_aaaa_bbbb_cccc);
        issue(MEM_OP_LD, addr_with_index(8'h14), '0);
        issue(MEM_OP_LD, addr_with_index(8'h7f), '0);

        // Unused op codes
        for (k = 11; k <= 15; k++) begin
            issue(mem_op_t'(4'(k)), addr_with_index(8'(k * 3)), {$urandom(), $urandom()});
        end
        issue(mem_op_t'(4'd12), addr_with_index(8'hc0), '0);

        for (i = 0; i < RAND_OPS; i++) begin
            issue(mem_op_t'(4'($urandom_range(15, 0))),
                  addr_with_index(8'($urandom_range(255, 0))),
                  {$urandom(), $urandom()});
        end

        // Let the compare process drain
        repeat (2) @(posedge clk_i);
        $display("Checks: %0d, check errors: %0d, timeouts: %0d",
                 check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/secv_pkg.sv
design/secv_mem.sv
design/secv_dmem.sv
design/secv_mem_top.sv
dv/secv_mem_sva.sv
dv/secv_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the secv memory unit bench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found on the PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module secv_mem_tb \
    -Mdir obj_dir -o secv_mem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/secv_mem_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
